// ==== bench/spiMasterTb.sv ====
`include "spi_consts.svh"

module spiMasterTb import spiPkg::*; ();

	localparam int numRows = 18;

	logic clk = 1'b0;
	logic ireset;
	logic [11:0] ramAddr;
	logic ramRe;
	logic ramWe;
	spiByte_t dbusIn;
	spiByte_t dbusOut;
	logic outEn;
	logic miso = 1'b0;
	logic mosi;
	logic sck;
	logic spiIrq;
	logic [5:0] irqAckAddr;
	logic irqAck;

	// Stimulus table with one row per transfer
	spiByte_t rowSpcr [numRows];
	logic rowX2 [numRows];
	logic [1:0] rowKind [numRows];   // 0 plain, 1 collision, 2 acknowledge
	spiByte_t rowTx [numRows];
	spiByte_t rowReply [numRows];
	spiByte_t rowCap [numRows];      // Expected byte at the slave

	integer seed;

	// Slave model settings from the main sequence
	logic curCpol;
	logic curCpha;
	spiByte_t slvLine;               // Reply in line order
	int armCount = 0;

	// Slave model state
	int lastArm = 0;
	logic slvOn = 1'b0;
	logic prevSck = 1'b0;
	spiByte_t slvOut = '0;
	int slvLeft = 0;
	int slvEdges = 0;
	spiByte_t slvCap = '0;

	always #2 clk = ~clk;

	spiMaster DUT (
		.cp2(clk),
		.ireset(ireset),
		.ramAddr_i(ramAddr),
		.ramRe_i(ramRe),
		.ramWe_i(ramWe),
		.dbus_i(dbusIn),
		.dbus_o(dbusOut),
		.outEn_o(outEn),
		.miso_i(miso),
		.mosi_o(mosi),
		.sck_o(sck),
		.spiIrq_o(spiIrq),
		.irqAckAddr_i(irqAckAddr),
		.irqAck_i(irqAck)
	);

	// ****************************************
	// SPI slave model
	// ****************************************

	always @(posedge clk) begin : slaveModel
		logic isLead;
		#1;
		if (armCount != lastArm) begin
			lastArm = armCount;
			slvOn = 1'b1;
			slvEdges = 0;
			slvCap = '0;
			slvOut = slvLine;
			slvLeft = 8;
			if (!curCpha) begin
				miso = slvOut[7];            // First bit before any edge
				slvOut = {slvOut[6:0], 1'b0};
				slvLeft = 7;
			end
		end else if (slvOn && (sck != prevSck)) begin
			isLead = (sck != curCpol);
			if (isLead != curCpha) begin
				slvCap = {slvCap[6:0], mosi};  // Sample edge
			end else if (slvLeft > 0) begin
				miso = slvOut[7];
				slvOut = {slvOut[6:0], 1'b0};
				slvLeft--;
			end
			slvEdges++;
			if (slvEdges == 16) begin
				slvOn = 1'b0;
			end
		end
		prevSck = sck;
	end

	// ****************************************
	// Bus and check tasks
	// ****************************************

	task automatic checkEq(input spiByte_t got, input spiByte_t exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s, got %02h, expected %02h", $time, what, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic waitClk(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic busWrite(input logic [11:0] addr, input spiByte_t data);
		ramAddr = addr;
		dbusIn = data;
		ramWe = 1'b1;
		@(posedge clk);
		#1;
		ramWe = 1'b0;
	endtask

	task automatic busRead(input logic [11:0] addr, output spiByte_t data, output logic en);
		ramAddr = addr;
		ramRe = 1'b1;
		@(negedge clk);                  // Read data is combinational
		data = dbusOut;
		en = outEn;
		@(posedge clk);
		#1;
		ramRe = 1'b0;
	endtask

	task automatic readCheck(input logic [11:0] addr, input spiByte_t exp, input string what);
		spiByte_t data;
		logic en;
		busRead(addr, data, en);
		checkEq({7'd0, en}, 8'd1, {what, " output enable"});
		checkEq(data, exp, what);
	endtask

	task automatic ackPulse(input logic [5:0] vec);
		irqAckAddr = vec;
		irqAck = 1'b1;
		@(posedge clk);
		#1;
		irqAck = 1'b0;
	endtask

	// Poll SPSR until the transfer-complete flag shows up
	task automatic waitSpif(output spiByte_t spsr);
		logic en;
		int polls;
		polls = 0;
		spsr = '0;
		while (!spsr[`BIT_SPIF] && (polls < 3000)) begin
			busRead(`SPSR_ADDR, spsr, en);
			polls++;
		end
		if (!spsr[`BIT_SPIF]) begin
			$display("Timeout: SPIF never came up after the SPDR write");
			$display("*** FAILED ***");
			$fatal(1, "Transfer did not finish");
		end
	endtask

	function automatic spiByte_t flipBits(input spiByte_t b);
		return {b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7]};
	endfunction

	// ****************************************
	// Stimulus table
	// ****************************************

	task automatic setRow(input logic [4:0] idx, input spiByte_t spcr, input logic x2,
			input logic [1:0] kind);
		logic [31:0] rnd;
		rnd = $random(seed);
		rowSpcr[idx] = spcr;
		rowX2[idx] = x2;
		rowKind[idx] = kind;
		rowTx[idx] = rnd[7:0];
		rowReply[idx] = rnd[15:8];
		rowCap[idx] = spcr[`BIT_DORD] ? flipBits(rnd[7:0]) : rnd[7:0];
	endtask

	task automatic loadTable();
		setRow(5'd0, 8'h50, 1'b0, 2'd0);   // Mode 0 at divide by 4
		setRow(5'd1, 8'h55, 1'b0, 2'd0);
		setRow(5'd2, 8'h5A, 1'b0, 2'd0);
		setRow(5'd3, 8'h5F, 1'b0, 2'd0);   // Mode 3 at divide by 128
		setRow(5'd4, 8'h70, 1'b1, 2'd0);   // LSB first from here
		setRow(5'd5, 8'h75, 1'b1, 2'd0);
		setRow(5'd6, 8'h7A, 1'b1, 2'd0);
		setRow(5'd7, 8'h7F, 1'b1, 2'd0);
		setRow(5'd8, 8'hD4, 1'b1, 2'd0);   // Interrupt enabled
		setRow(5'd9, 8'hD9, 1'b0, 2'd0);
		setRow(5'd10, 8'hF1, 1'b0, 2'd0);
		setRow(5'd11, 8'hFE, 1'b1, 2'd0);
		setRow(5'd12, 8'h7B, 1'b0, 2'd0);
		setRow(5'd13, 8'h56, 1'b0, 2'd0);
		setRow(5'd14, 8'hDC, 1'b0, 2'd0);
		setRow(5'd15, 8'h73, 1'b1, 2'd0);
		setRow(5'd16, 8'h76, 1'b0, 2'd1);  // Second write mid-transfer
		setRow(5'd17, 8'hD1, 1'b0, 2'd2);  // Cleared by acknowledge
	endtask

	task automatic runRow(input logic [4:0] r);
		spiByte_t spcr;
		spiByte_t x2Byte;
		spiByte_t spsr;
		spiByte_t spsrExp;
		spcr = rowSpcr[r];
		x2Byte = {7'd0, rowX2[r]};
		spsrExp = {1'b1, rowKind[r] == 2'd1, 5'd0, rowX2[r]};
		busWrite(`SPCR_ADDR, spcr);
		busWrite(`SPSR_ADDR, x2Byte);
		readCheck(`SPCR_ADDR, spcr, "SPCR readback");
		readCheck(`SPSR_ADDR, x2Byte, "SPSR before transfer");
		checkEq({7'd0, sck}, {7'd0, spcr[`BIT_CPOL]}, "sck parked before transfer");

		curCpol = spcr[`BIT_CPOL];
		curCpha = spcr[`BIT_CPHA];
		slvLine = spcr[`BIT_DORD] ? flipBits(rowReply[r]) : rowReply[r];
		armCount++;
		waitClk(1);
		busWrite(`SPDR_ADDR, rowTx[r]);
		if (rowKind[r] == 2'd1) begin
			waitClk(3);
			busWrite(`SPDR_ADDR, ~rowTx[r]);  // Engine is busy here
		end

		waitSpif(spsr);
		checkEq(spsr, spsrExp, "SPSR after transfer");
		checkEq({7'd0, spiIrq}, {7'd0, spcr[`BIT_SPIE]}, "interrupt request");
		checkEq(slvCap, rowCap[r], "byte seen by slave");
		checkEq({7'd0, sck}, {7'd0, spcr[`BIT_CPOL]}, "sck parked after transfer");

		if (rowKind[r] == 2'd2) begin
			ackPulse(6'h15);
			readCheck(`SPSR_ADDR, spsrExp, "SPSR after foreign acknowledge");
			ackPulse(`SPI_IRQ_VEC);
			readCheck(`SPSR_ADDR, x2Byte, "SPSR after acknowledge");
		end
		readCheck(`SPDR_ADDR, rowReply[r], "SPDR reply");
		readCheck(`SPSR_ADDR, x2Byte, "SPSR after clear");
		checkEq({7'd0, spiIrq}, 8'd0, "interrupt request after clear");
	endtask

	// ****************************************
	// Main sequence
	// ****************************************

	initial begin : mainSeq
		spiByte_t data;
		logic en;
		seed = 25;
		ireset = 1'b0;
		ramAddr = '0;
		ramRe = 1'b0;
		ramWe = 1'b0;
		dbusIn = '0;
		irqAckAddr = '0;
		irqAck = 1'b0;
		curCpol = 1'b0;
		curCpha = 1'b0;
		slvLine = '0;
		loadTable();

		waitClk(16);
		ireset = 1'b1;
		waitClk(2);

		checkEq({7'd0, sck}, 8'd0, "sck after reset");
		checkEq({7'd0, mosi}, 8'd0, "mosi after reset");
		checkEq({7'd0, spiIrq}, 8'd0, "interrupt request after reset");
		readCheck(`SPCR_ADDR, 8'h00, "SPCR after reset");
		readCheck(`SPSR_ADDR, 8'h00, "SPSR after reset");
		busRead(12'h0AF, data, en);
		checkEq({7'd0, en}, 8'd0, "output enable at unmapped address");

		for (int i = 0; i < numRows; i++) begin
			runRow(5'(i));
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== include/spi_consts.svh ====
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// Register map
`define SPCR_ADDR   12'h0AC
`define SPSR_ADDR   12'h0AD
`define SPDR_ADDR   12'h0AE

`define SPI_IRQ_VEC 6'h27   // Transfer complete vector

// SPCR bits
`define BIT_SPIE    7
`define BIT_SPE     6
`define BIT_DORD    5
`define BIT_MSTR    4
`define BIT_CPOL    3
`define BIT_CPHA    2

// SPSR bits
`define BIT_SPIF    7
`define BIT_WCOL    6
`define BIT_SPI2X   0

// Divider counter and terminal counts, one half period each
`define DIV_W       6
`define DIV_TC_2    6'd0
`define DIV_TC_4    6'd1
`define DIV_TC_8    6'd3
`define DIV_TC_16   6'd7
`define DIV_TC_32   6'd15
`define DIV_TC_64   6'd31
`define DIV_TC_128  6'd63

`endif

// ==== rtl/spiClockGen.sv ====
`include "spi_consts.svh"

module spiClockGen import spiPkg::*; (
	input  logic       cp2,
	input  logic       ireset,
	input  logic       busy_i,
	spiCtrlIf.engine   ctrl,
	output logic       sck_o,
	output logic       leadStb_o,
	output logic       trailStb_o
);

	logic [`DIV_W-1:0] divCnt;
	logic [`DIV_W-1:0] termCnt;
	logic phase;       // Set between leading and trailing edge
	logic toggle;
	clkSel_t sel;

	assign sel = ctrl.clkSel;

	// Half period minus one
	always_comb begin
		case (sel)
			3'b000:  termCnt = `DIV_TC_4;
			3'b001:  termCnt = `DIV_TC_16;
			3'b010:  termCnt = `DIV_TC_64;
			3'b011:  termCnt = `DIV_TC_128;
			3'b100:  termCnt = `DIV_TC_2;
			3'b101:  termCnt = `DIV_TC_8;
			3'b110:  termCnt = `DIV_TC_32;
			default: termCnt = `DIV_TC_64;
		endcase
	end

	// >= covers a rate change while running
	assign toggle = busy_i & (divCnt >= termCnt);

	always_ff @(posedge cp2) begin
		if (!ireset) begin
			divCnt <= '0;
			phase <= 1'b0;
		end else if (!busy_i) begin
			divCnt <= '0;  // Each byte starts a full half period away
			phase <= 1'b0;
		end else if (toggle) begin
			divCnt <= '0;
			phase <= ~phase;
		end else begin
			divCnt <= divCnt + 1'b1;
		end
	end

	assign leadStb_o = toggle & ~phase;
	assign trailStb_o = toggle & phase;

	// Parked at CPOL whenever idle
	assign sck_o = busy_i ? (ctrl.cpol ^ phase) : ctrl.cpol;

endmodule

// ==== rtl/spiCtrlIf.sv ====
interface spiCtrlIf import spiPkg::*; ();

	logic cpol;        // Idle level of sck
	logic cpha;        // Sample on trailing edge when set
	logic dord;        // LSB first when set
	clkSel_t clkSel;
	logic start;       // One cycle, SPDR write accepted
	spiByte_t txByte;  // Valid with start

	// Register side
	modport regs (
		output cpol,
		output cpha,
		output dord,
		output clkSel,
		output start,
		output txByte
	);

	// Clock generator and shift register side
	modport engine (
		input cpol,
		input cpha,
		input dord,
		input clkSel,
		input start,
		input txByte
	);

endinterface

// ==== rtl/spiMaster.sv ====
module spiMaster import spiPkg::*; (
	input  logic        cp2,
	input  logic        ireset,
	input  logic [11:0] ramAddr_i,
	input  logic        ramRe_i,
	input  logic        ramWe_i,
	input  spiByte_t    dbus_i,
	output spiByte_t    dbus_o,
	output logic        outEn_o,
	input  logic        miso_i,
	output logic        mosi_o,
	output logic        sck_o,
	output logic        spiIrq_o,
	input  logic [5:0]  irqAckAddr_i,
	input  logic        irqAck_i
);

	logic busy;
	logic byteDone;
	spiByte_t rxByte;
	logic leadStb;
	logic trailStb;
	logic spdrRd;
	logic spdrWr;
	logic spsrRd;
	logic spe;
	logic irqAck;
	logic spif;
	logic wcol;
	spiByte_t rxData;

	spiCtrlIf ctrl ();

	spiRegFile regFile (
		.cp2(cp2),
		.ireset(ireset),
		.ramAddr_i(ramAddr_i),
		.ramRe_i(ramRe_i),
		.ramWe_i(ramWe_i),
		.dbus_i(dbus_i),
		.irqAckAddr_i(irqAckAddr_i),
		.irqAck_i(irqAck_i),
		.busy_i(busy),
		.spif_i(spif),
		.wcol_i(wcol),
		.rxData_i(rxData),
		.ctrl(ctrl.regs),
		.spdrRd_o(spdrRd),
		.spdrWr_o(spdrWr),
		.spsrRd_o(spsrRd),
		.spe_o(spe),
		.irqAck_o(irqAck),
		.dbus_o(dbus_o),
		.outEn_o(outEn_o),
		.spiIrq_o(spiIrq_o)
	);

	spiRxBuffer rxBuffer (
		.cp2(cp2),
		.ireset(ireset),
		.spdrRd_i(spdrRd),
		.spdrWr_i(spdrWr),
		.spsrRd_i(spsrRd),
		.spe_i(spe),
		.irqAck_i(irqAck),
		.busy_i(busy),
		.byteDone_i(byteDone),
		.dord_i(ctrl.dord),
		.rxByte_i(rxByte),
		.spif_o(spif),
		.wcol_o(wcol),
		.rxData_o(rxData)
	);

	spiClockGen clockGen (
		.cp2(cp2),
		.ireset(ireset),
		.busy_i(busy),
		.ctrl(ctrl.engine),
		.sck_o(sck_o),
		.leadStb_o(leadStb),
		.trailStb_o(trailStb)
	);

	spiShifter shifter (
		.cp2(cp2),
		.ireset(ireset),
		.ctrl(ctrl.engine),
		.leadStb_i(leadStb),
		.trailStb_i(trailStb),
		.busy_o(busy),
		.byteDone_o(byteDone),
		.rxByte_o(rxByte),
		.miso_i(miso_i),
		.mosi_o(mosi_o)
	);

endmodule

// ==== rtl/spiPkg.sv ====
package spiPkg;

	// One byte on the register bus or on the serial line
	typedef logic [7:0] spiByte_t;

	// {SPI2X, SPR1, SPR0}
	typedef logic [2:0] clkSel_t;

	// LSB-first bytes go through the shift register reversed
	function automatic spiByte_t revByte(input spiByte_t inByte);
		spiByte_t outByte;
		for (int i = 0; i < 8; i++) begin
			outByte[i] = inByte[7 - i];
		end
		return outByte;
	endfunction

endpackage

// ==== rtl/spiRegFile.sv ====
`include "spi_consts.svh"

module spiRegFile import spiPkg::*; (
	input  logic        cp2,
	input  logic        ireset,
	input  logic [11:0] ramAddr_i,
	input  logic        ramRe_i,
	input  logic        ramWe_i,
	input  spiByte_t    dbus_i,
	input  logic [5:0]  irqAckAddr_i,
	input  logic        irqAck_i,
	input  logic        busy_i,
	input  logic        spif_i,
	input  logic        wcol_i,
	input  spiByte_t    rxData_i,
	spiCtrlIf.regs      ctrl,
	output logic        spdrRd_o,
	output logic        spdrWr_o,
	output logic        spsrRd_o,
	output logic        spe_o,
	output logic        irqAck_o,
	output spiByte_t    dbus_o,
	output logic        outEn_o,
	output logic        spiIrq_o
);

	spiByte_t spcr;
	logic spi2x;
	logic spcrSel;
	logic spsrSel;
	logic spdrSel;

	// ****************************************
	// Address decode
	// ****************************************

	assign spcrSel = (ramAddr_i == `SPCR_ADDR);
	assign spsrSel = (ramAddr_i == `SPSR_ADDR);
	assign spdrSel = (ramAddr_i == `SPDR_ADDR);

	assign spdrRd_o = spdrSel & ramRe_i;
	assign spdrWr_o = spdrSel & ramWe_i;
	assign spsrRd_o = spsrSel & ramRe_i;
	assign irqAck_o = irqAck_i & (irqAckAddr_i == `SPI_IRQ_VEC);

	// ****************************************
	// Control registers
	// ****************************************

	always_ff @(posedge cp2) begin
		if (!ireset) begin
			spcr <= '0;
			spi2x <= 1'b0;
		end else begin
			if (spcrSel && ramWe_i) begin
				spcr <= dbus_i;
			end
			if (spsrSel && ramWe_i) begin
				spi2x <= dbus_i[`BIT_SPI2X];  // Only writable SPSR bit
			end
		end
	end

	assign spe_o = spcr[`BIT_SPE];

	assign ctrl.cpol = spcr[`BIT_CPOL];
	assign ctrl.cpha = spcr[`BIT_CPHA];
	assign ctrl.dord = spcr[`BIT_DORD];
	assign ctrl.clkSel = {spi2x, spcr[1:0]};

	// Master transfer kicks off only from idle
	assign ctrl.start = spdrWr_o & spcr[`BIT_SPE] & spcr[`BIT_MSTR] & ~busy_i;
	assign ctrl.txByte = dbus_i;

	// ****************************************
	// Read data and interrupt
	// ****************************************

	always_comb begin
		dbus_o = '0;
		outEn_o = 1'b0;
		if (spcrSel) begin
			dbus_o = spcr;
			outEn_o = ramRe_i;
		end else if (spsrSel) begin
			dbus_o = {spif_i, wcol_i, 5'b0, spi2x};
			outEn_o = ramRe_i;
		end else if (spdrSel) begin
			dbus_o = rxData_i;
			outEn_o = ramRe_i;
		end
	end

	assign spiIrq_o = spcr[`BIT_SPIE] & spif_i;

endmodule

// ==== rtl/spiRxBuffer.sv ====
module spiRxBuffer import spiPkg::*; (
	input  logic     cp2,
	input  logic     ireset,
	input  logic     spdrRd_i,
	input  logic     spdrWr_i,
	input  logic     spsrRd_i,
	input  logic     spe_i,
	input  logic     irqAck_i,
	input  logic     busy_i,
	input  logic     byteDone_i,
	input  logic     dord_i,
	input  spiByte_t rxByte_i,
	output logic     spif_o,
	output logic     wcol_o,
	output spiByte_t rxData_o
);

	logic spifArm;    // SPSR seen with SPIF set
	logic wcolArm;    // SPSR seen with WCOL set
	logic spdrAcc;
	logic wcolSet;

	assign spdrAcc = spdrRd_i | spdrWr_i;
	assign wcolSet = spdrWr_i & busy_i;   // Write lands mid-transfer

	// Received byte back in memory order
	always_ff @(posedge cp2) begin
		if (byteDone_i) begin
			rxData_o <= dord_i ? revByte(rxByte_i) : rxByte_i;
		end
	end

	// ****************************************
	// Flags and their clear sequences
	// ****************************************

	always_ff @(posedge cp2) begin
		if (!ireset) begin
			spif_o <= 1'b0;
			wcol_o <= 1'b0;
			spifArm <= 1'b0;
			wcolArm <= 1'b0;
		end else begin
			if (byteDone_i) begin
				spif_o <= 1'b1;  // New byte beats a pending clear
			end else if ((spifArm && spdrAcc) || irqAck_i) begin
				spif_o <= 1'b0;
			end

			if (wcolSet) begin
				wcol_o <= 1'b1;
			end else if (wcolArm && spdrAcc) begin
				wcol_o <= 1'b0;
			end

			if (!spifArm) begin
				spifArm <= spsrRd_i & spif_o & spe_i;
			end else if (spdrAcc) begin
				spifArm <= 1'b0;
			end

			if (!wcolArm) begin
				wcolArm <= spsrRd_i & wcol_o;
			end else if (spdrAcc) begin
				wcolArm <= 1'b0;
			end
		end
	end

endmodule

// ==== rtl/spiShifter.sv ====
module spiShifter import spiPkg::*; (
	input  logic     cp2,
	input  logic     ireset,
	spiCtrlIf.engine ctrl,
	input  logic     leadStb_i,
	input  logic     trailStb_i,
	output logic     busy_o,
	output logic     byteDone_o,
	output spiByte_t rxByte_o,
	input  logic     miso_i,
	output logic     mosi_o
);

	spiByte_t shReg;
	spiByte_t loadByte;
	logic [3:0] edgeCnt;   // sck edges seen in this byte
	logic misoLat;
	logic anyStb;
	logic sampleStb;
	logic shiftStb;
	logic firstLead;

	assign loadByte = ctrl.dord ? revByte(ctrl.txByte) : ctrl.txByte;

	assign anyStb = leadStb_i | trailStb_i;
	assign sampleStb = ctrl.cpha ? trailStb_i : leadStb_i;
	assign shiftStb = ctrl.cpha ? leadStb_i : trailStb_i;

	// CPHA=1 leading edge only drives out the first bit
	assign firstLead = ctrl.cpha & leadStb_i & (edgeCnt == 4'd0);

	// ****************************************
	// Byte sequencing
	// ****************************************

	always_ff @(posedge cp2) begin
		if (!ireset) begin
			busy_o <= 1'b0;
			byteDone_o <= 1'b0;
			edgeCnt <= '0;
		end else begin
			byteDone_o <= 1'b0;
			if (ctrl.start) begin
				busy_o <= 1'b1;
				edgeCnt <= '0;
			end else if (busy_o && anyStb) begin
				edgeCnt <= edgeCnt + 4'd1;
				if (edgeCnt == 4'd15) begin  // 16th edge closes the byte
					busy_o <= 1'b0;
					byteDone_o <= 1'b1;
				end
			end
		end
	end

	// ****************************************
	// Data path
	// ****************************************

	always_ff @(posedge cp2) begin
		if (ctrl.start) begin
			shReg <= loadByte;
		end else if (shiftStb && !firstLead) begin
			shReg <= {shReg[6:0], misoLat};
		end
		if (sampleStb) begin
			misoLat <= miso_i;
		end
	end

	always_ff @(posedge cp2) begin
		if (!ireset) begin
			mosi_o <= 1'b0;
		end else if (ctrl.start && !ctrl.cpha) begin
			mosi_o <= loadByte[7];   // First bit out before first edge
		end else if (firstLead) begin
			mosi_o <= shReg[7];
		end else if (shiftStb) begin
			mosi_o <= shReg[6];      // Bit that moves to the top
		end
	end

	// Last sampled bit is still in the latch for CPHA=1
	assign rxByte_o = ctrl.cpha ? {shReg[6:0], misoLat} : shReg;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the SPI master testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing -f vlog.f --top-module spiMasterTb --Mdir "$BUILD" -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qF "*** FAILED ***" "$LOG"; then
	echo "Testbench reported a failure"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== vlog.f ====
+incdir+include
rtl/spiPkg.sv
rtl/spiCtrlIf.sv
rtl/spiRegFile.sv
rtl/spiRxBuffer.sv
rtl/spiClockGen.sv
rtl/spiShifter.sv
rtl/spiMaster.sv
bench/spiMasterTb.sv
